// File: common/rf_pkg.sv
//--------------------
// Shared sizes and port structs for the power-gated 16x180 register file
// Both clocks are assumed to run at the same rate with unrelated phase
// Power and memory reset may change only after four idle cycles on both ports
//--------------------

package rf_pkg;

    //--------------------
    // Array geometry
    //--------------------

    // Number of words held in the array
    localparam int rf_depth = 16;

    // Width of one stored word
    localparam int rf_width = 180;

    // Address width needed to select one of rf_depth words
    localparam int rf_addr_w = 4;

    //--------------------
    // Power sequencing
    //--------------------

    // Read clock cycles from a wake request to the falling acknowledge
    localparam int pwr_wake_cycles = 4;

    // The wake counter must be able to hold the full reload value
    localparam int pwr_cnt_w = $clog2(pwr_wake_cycles + 1);

    //--------------------
    // Port bundles
    //--------------------

    // Everything the write port samples on one wclk edge
    typedef struct packed {
        logic                 we;
        logic [rf_addr_w-1:0] waddr;
        logic [rf_width-1:0]  wdata;
    } rf_wr_t;

    // Everything the read port samples on one rclk edge
    typedef struct packed {
        logic                 re;
        logic [rf_addr_w-1:0] raddr;
    } rf_rd_t;

    // Power controls from the power gating controller, both are levels
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } rf_pwr_t;

endpackage

// File: logic/mem_reset_sync.sv
//--------------------
// Two-flop synchronizer for the array memory reset, one per clock domain
// Output follows the input two edges later on clk
// Scan bypass drives the output straight from fscan_byprst_b
//--------------------

`timescale 1ns/100ps

module mem_reset_sync (
     input  logic clk
    ,input  logic rst_n
    ,input  logic mem_rst_n_in
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic mem_rst_n_sync
);

    // Stage 0 may go metastable, stage 1 is the settled copy
    logic [1:0] sync_q;

    //--------------------
    // Synchronizer chain
    //--------------------

    // A cleared chain keeps the array in memory reset right after rst_n
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], mem_rst_n_in};
        end
    end

    //--------------------
    // Scan bypass
    //--------------------

    // In scan the reset is controlled directly from the tester
    assign mem_rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

endmodule

// File: rf_array/rf_pwr_seq.sv
//--------------------
// Power-enable sequencer on rclk
// Power-down is acknowledged one cycle after the request rises
// Power-up is acknowledged pwr_wake_cycles cycles after the request falls
// Any toggle of the request during the wake count starts the count over
//--------------------

`timescale 1ns/100ps

module rf_pwr_seq (
     input  logic rclk
    ,input  logic rst_n
    ,input  logic pwr_enable_b_in
    ,output logic pwr_enable_b_out
    ,output logic powered
);

    // Request as seen on the previous rclk edge
    logic                         pwr_in_q;

    // Cycles left until the wake acknowledge, zero when idle
    logic [rf_pkg::pwr_cnt_w-1:0] wake_cnt;

    // High on the first edge that sees a wake request
    logic                         req_fall;

    // Marks the edge where the count runs out
    logic                         wake_done;

    //--------------------
    // Request edge detect
    //--------------------

    // The request flop resets high, so a request that is already low when
    // rst_n releases still counts as a fresh wake request
    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            pwr_in_q <= 1'b1;
        end else begin
            pwr_in_q <= pwr_enable_b_in;
        end
    end

    assign req_fall = pwr_in_q & ~pwr_enable_b_in;

    //--------------------
    // Wake counter
    //--------------------

    // The load value makes the output fall on the fourth edge after the request
    // A rising request clears the count so the next fall starts from the top
    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            wake_cnt <= '0;
        end else if (pwr_enable_b_in) begin
            wake_cnt <= '0;
        end else if (req_fall) begin
            wake_cnt <= rf_pkg::pwr_cnt_w'(rf_pkg::pwr_wake_cycles - 1);
        end else if (wake_cnt != '0) begin
            wake_cnt <= wake_cnt - rf_pkg::pwr_cnt_w'(1);
        end
    end

    assign wake_done = ~pwr_enable_b_in & (wake_cnt == rf_pkg::pwr_cnt_w'(1));

    //--------------------
    // Acknowledge flop
    //--------------------

    // Power-down is taken at once, power-up only when the count expires
    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            pwr_enable_b_out <= 1'b1;
        end else if (pwr_enable_b_in) begin
            pwr_enable_b_out <= 1'b1;
        end else if (wake_done) begin
            pwr_enable_b_out <= 1'b0;
        end
    end

    // The array counts as powered exactly while the acknowledge is low
    assign powered = ~pwr_enable_b_out;

endmodule

// File: rf_array/rf_array_2p.sv
//--------------------
// Two-port storage array with one valid bit per word
// Writes on wclk, registered reads on rclk with one cycle of latency
// Valid bits live on wclk and are read from rclk without a crossing
// The idle-port rule around power and reset changes keeps that safe
//--------------------

`timescale 1ns/100ps

module rf_array_2p (
     input  logic                        wclk
    ,input  logic                        rclk
    ,input  logic                        rst_n
    ,input  rf_pkg::rf_wr_t              wr
    ,input  rf_pkg::rf_rd_t              rd
    ,input  logic                        isol_en
    ,input  logic                        powered
    ,input  logic                        wr_mem_rst_n
    ,input  logic                        rd_mem_rst_n
    ,output logic [rf_pkg::rf_width-1:0] rdata
);

    // Word storage, contents are only trusted where the valid bit is set
    logic [rf_pkg::rf_width-1:0] mem [rf_pkg::rf_depth];

    // One bit per word, set by a write and cleared by power loss or reset
    logic [rf_pkg::rf_depth-1:0] valid_q;

    // Qualified write strobe
    logic                        wr_en;

    // The addressed word holds data that may be returned
    logic                        rd_hit;

    // Held read result before the isolation clamp
    logic [rf_pkg::rf_width-1:0] rdata_q;

    //--------------------
    // Write port
    //--------------------

    // A write only lands while the array is powered and out of memory reset
    assign wr_en = wr.we & powered & wr_mem_rst_n;

    // The storage itself is never cleared
    // Stale words are hidden by their valid bits instead
    always_ff @(posedge wclk) begin
        if (wr_en) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    //--------------------
    // Valid tracking
    //--------------------

    // Losing power or entering memory reset forgets every word
    // The bits stay clear for as long as either condition holds
    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (!powered || !wr_mem_rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr.waddr] <= 1'b1;
        end
    end

    //--------------------
    // Read port
    //--------------------

    // powered is an rclk signal, so using it here makes the read side see
    // the power-down on the same edge as the acknowledge
    assign rd_hit = valid_q[rd.raddr] & powered;

    // The read register holds its value between strobes
    // Memory reset on the read side holds it at zero
    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (!rd_mem_rst_n) begin
            rdata_q <= '0;
        end else if (rd.re) begin
            if (rd_hit) begin
                rdata_q <= mem[rd.raddr];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    //--------------------
    // Isolation clamp
    //--------------------

    // Isolation forces zero without touching the held value
    // so the last read shows again once isolation drops
    assign rdata = isol_en ? '0 : rdata_q;

endmodule

// File: rf_array/rf_pg_16x180.sv
//--------------------
// Power-gated two-port register file, 16 words of 180 bits
// Reads return data one rclk cycle after re and hold until the next read
// Power and memory reset may change only after both ports are idle
// for four cycles, there is no clock-crossing logic between wclk and rclk
//--------------------

`timescale 1ns/100ps

module rf_pg_16x180 (
     input  logic                        wclk
    ,input  logic                        rst_n
    ,input  rf_pkg::rf_wr_t              wr

    ,input  logic                        rclk
    ,input  rf_pkg::rf_rd_t              rd
    ,output logic [rf_pkg::rf_width-1:0] rdata

    // Power gating controls
    ,input  rf_pkg::rf_pwr_t             pwr
    ,output logic                        pwr_enable_b_out

    // Memory reset from the IP reset controller
    ,input  logic                        ip_reset_b

    // Scan reset bypass
    ,input  logic                        fscan_rstbypen
    ,input  logic                        fscan_byprst_b
);

    // Memory reset as seen in the write clock domain
    logic wr_mem_rst_n;

    // Memory reset as seen in the read clock domain
    logic rd_mem_rst_n;

    // High while the sequencer reports the array as awake
    logic powered;

    //--------------------
    // Memory reset synchronizers
    //--------------------

    // Each port gets its own copy so both sides leave reset cleanly
    mem_reset_sync u_wr_rst_sync (
         .clk             (wclk)
        ,.rst_n           (rst_n)
        ,.mem_rst_n_in    (ip_reset_b)
        ,.fscan_rstbypen  (fscan_rstbypen)
        ,.fscan_byprst_b  (fscan_byprst_b)
        ,.mem_rst_n_sync  (wr_mem_rst_n)
    );

    mem_reset_sync u_rd_rst_sync (
         .clk             (rclk)
        ,.rst_n           (rst_n)
        ,.mem_rst_n_in    (ip_reset_b)
        ,.fscan_rstbypen  (fscan_rstbypen)
        ,.fscan_byprst_b  (fscan_byprst_b)
        ,.mem_rst_n_sync  (rd_mem_rst_n)
    );

    //--------------------
    // Power sequencer
    //--------------------

    // Runs on the read clock, like the acknowledge of the hard macro
    rf_pwr_seq u_pwr_seq (
         .rclk              (rclk)
        ,.rst_n             (rst_n)
        ,.pwr_enable_b_in   (pwr.pwr_enable_b)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.powered           (powered)
    );

    //--------------------
    // Storage array
    //--------------------

    rf_array_2p u_array (
         .wclk          (wclk)
        ,.rclk          (rclk)
        ,.rst_n         (rst_n)
        ,.wr            (wr)
        ,.rd            (rd)
        ,.isol_en       (pwr.isol_en)
        ,.powered       (powered)
        ,.wr_mem_rst_n  (wr_mem_rst_n)
        ,.rd_mem_rst_n  (rd_mem_rst_n)
        ,.rdata         (rdata)
    );

endmodule

// File: tb/rf_pg_props.sv
//--------------------
// Concurrent assertions bound into the register file top level
// The idle rule is sampled on wclk for both strobes
//--------------------

`timescale 1ns/100ps

module rf_pg_props (
     input  logic                        wclk
    ,input  logic                        rclk
    ,input  logic                        rst_n
    ,input  rf_pkg::rf_wr_t              wr
    ,input  rf_pkg::rf_rd_t              rd
    ,input  rf_pkg::rf_pwr_t             pwr
    ,input  logic                        ip_reset_b
    ,input  logic                        fscan_rstbypen
    ,input  logic                        fscan_byprst_b
    ,input  logic [rf_pkg::rf_width-1:0] rdata
    ,input  logic                        powered
    ,input  logic                        pwr_enable_b_out
);

    int         assert_errors = 0;
    logic       act;
    logic [3:0] ctl;

    assign act = wr.we | rd.re;
    assign ctl = {pwr.pwr_enable_b, ip_reset_b, fscan_rstbypen, fscan_byprst_b};

    assert property (@(posedge rclk) disable iff (!rst_n) pwr.isol_en |-> rdata == '0)
        else begin assert_errors++; $error("rdata is not zero during isolation"); end

    assert property (@(posedge rclk) disable iff (!rst_n) !powered |-> pwr_enable_b_out)
        else begin assert_errors++; $error("array unpowered with acknowledge low"); end

    // Strobes stay quiet four cycles either side of a control change
    assert property (@(posedge wclk) disable iff (!rst_n)
        $changed(ctl) |-> !(act | $past(act, 1) | $past(act, 2) | $past(act, 3)) ##1 !act [*3])
        else begin assert_errors++; $error("strobe too close to a control change"); end

endmodule

bind rf_pg_16x180 rf_pg_props u_props (.*);

// File: tb/rf_pg_checker.sv
//--------------------
// Watches the DUT ports and compares rdata and the power acknowledge
// Model follows the DUT rules, valid only under the idle-port rule
//--------------------

`timescale 1ns/100ps

module rf_pg_checker (
     input  logic                        wclk
    ,input  logic                        rclk
    ,input  logic                        rst_n
    ,input  rf_pkg::rf_wr_t              wr
    ,input  rf_pkg::rf_rd_t              rd
    ,input  rf_pkg::rf_pwr_t             pwr
    ,input  logic                        ip_reset_b
    ,input  logic                        fscan_rstbypen
    ,input  logic                        fscan_byprst_b
    ,input  logic [rf_pkg::rf_width-1:0] rdata
    ,input  logic                        pwr_enable_b_out
    ,output int                          data_errors
    ,output int                          pwr_errors
    ,output int                          checks
);

    logic [rf_pkg::rf_width-1:0] model_mem [rf_pkg::rf_depth];
    logic [rf_pkg::rf_depth-1:0] model_valid;
    logic                        model_ack;
    int                          low_edges;
    logic [1:0]                  wr_rst_hist;
    logic [1:0]                  rd_rst_hist;
    logic                        wr_in_reset;
    logic                        rd_in_reset;
    logic [rf_pkg::rf_width-1:0] exp_q;
    logic [rf_pkg::rf_width-1:0] exp_rdata;

    // Expected read result, zero for a forgotten word or an unpowered array
    function automatic logic [rf_pkg::rf_width-1:0] expected_read(
        input logic [rf_pkg::rf_addr_w-1:0] a);
        if (model_valid[a] && !model_ack) begin
            return model_mem[a];
        end
        return '0;
    endfunction

    //--------------------
    // Reference model
    //--------------------

    // Memory reset reaches each domain two of its own cycles later
    assign wr_in_reset = fscan_rstbypen ? !fscan_byprst_b : !wr_rst_hist[1];
    assign rd_in_reset = fscan_rstbypen ? !fscan_byprst_b : !rd_rst_hist[1];

    always @(posedge wclk) begin
        wr_rst_hist <= rst_n ? {wr_rst_hist[0], ip_reset_b} : 2'b00;
        if (!rst_n || model_ack || wr_in_reset) begin
            model_valid <= '0;
        end else if (wr.we) begin
            model_valid[wr.waddr] <= 1'b1;
            model_mem[wr.waddr]   <= wr.wdata;
        end
    end

    // Acknowledge rises on the first edge with the request high and
    // falls on the pwr_wake_cycles-th edge that sees it low
    always @(posedge rclk) begin
        rd_rst_hist <= rst_n ? {rd_rst_hist[0], ip_reset_b} : 2'b00;
        if (!rst_n || pwr.pwr_enable_b) begin
            model_ack <= 1'b1;
            low_edges <= 0;
        end else begin
            if (low_edges < rf_pkg::pwr_wake_cycles) low_edges <= low_edges + 1;
            if (low_edges + 1 == rf_pkg::pwr_wake_cycles) model_ack <= 1'b0;
        end
        if (!rst_n || rd_in_reset) begin
            exp_q <= '0;
        end else if (rd.re) begin
            exp_q <= expected_read(rd.raddr);
        end
    end

    //--------------------
    // Comparison
    //--------------------

    initial begin
        data_errors = 0;
        pwr_errors = 0;
        checks = 0;
    end

    // Falling read edge, halfway between updates of every DUT output
    always @(negedge rclk) begin
        if (rst_n) begin
            checks++;
            exp_rdata = pwr.isol_en ? '0 : exp_q;
            if (rdata !== exp_rdata) begin
                data_errors++;
                $display("** Error at %0t: rdata %h, expected %h", $time, rdata, exp_rdata);
            end
            if (pwr_enable_b_out !== model_ack) begin
                pwr_errors++;
                $display("** Error at %0t: pwr_enable_b_out %b, expected %b",
                         $time, pwr_enable_b_out, model_ack);
            end
        end
    end

endmodule

// File: tb/tb_rf_pg.sv
//--------------------
// Testbench top for the power-gated 16x180 register file
// Power, memory reset and scan levels change only with both ports idle
//--------------------

`timescale 1ns/100ps

module tb_rf_pg;

    // Random write and read rounds in the main test
    localparam int rand_ops = 40;

    // Cycle budget of the whole run before the watchdog margin
    localparam int test_cycles = 20 + 4 * rf_pkg::rf_depth * 2 + rand_ops * 6 + 150;

    logic                        wclk = 1'b0;
    logic                        rclk = 1'b0;
    logic                        rst_n;
    rf_pkg::rf_wr_t              wr;
    rf_pkg::rf_rd_t              rd;
    rf_pkg::rf_pwr_t             pwr;
    logic                        ip_reset_b;
    logic                        fscan_rstbypen;
    logic                        fscan_byprst_b;
    logic [rf_pkg::rf_width-1:0] rdata;
    logic                        pwr_enable_b_out;
    int                          data_errors;
    int                          pwr_errors;
    int                          checks;
    integer                      seed;
    logic [rf_pkg::rf_addr_w-1:0] addr;

    //--------------------
    // Clocks, DUT and checker
    //--------------------

    always #10 wclk = ~wclk;

    // The read clock is the write clock shifted by 5 ns
    always @(wclk) rclk <= #5 wclk;

    rf_pg_16x180 u_rf_pg_16x180 (.*);

    rf_pg_checker u_checker (.*);

    // Gives 180 random bits from six draws of the seeded generator
    function automatic logic [rf_pkg::rf_width-1:0] rand_data();
        logic [191:0] bits;
        bits = {$random(seed), $random(seed), $random(seed),
                $random(seed), $random(seed), $random(seed)};
        return bits[rf_pkg::rf_width-1:0];
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge wclk);
    endtask

    task automatic write_entry(input logic [rf_pkg::rf_addr_w-1:0] a,
                               input logic [rf_pkg::rf_width-1:0]  d);
        @(posedge wclk);
        wr.we    <= 1'b1;
        wr.waddr <= a;
        wr.wdata <= d;
        @(posedge wclk);
        wr.we    <= 1'b0;
    endtask

    task automatic read_entry(input logic [rf_pkg::rf_addr_w-1:0] a);
        @(posedge rclk);
        rd.re    <= 1'b1;
        rd.raddr <= a;
        @(posedge rclk);
        rd.re    <= 1'b0;
    endtask

    // Reads every entry once so the checker sees each word
    task automatic read_all();
        for (int i = 0; i < rf_pkg::rf_depth; i++) begin
            read_entry(rf_pkg::rf_addr_w'(i));
        end
    endtask

    //--------------------
    // Stimulus
    //--------------------

    initial begin
        seed = 32'h449e;
        rst_n = 1'b0;
        wr = '0;
        rd = '0;
        pwr = '0;
        ip_reset_b = 1'b1;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        repeat (10) @(posedge wclk);
        rst_n <= 1'b1;
        // The sequencer needs four cycles before the array wakes
        idle(8);
        read_all();

        // Each random write is read back and followed by a read elsewhere
        for (int i = 0; i < rand_ops; i++) begin
            addr = rf_pkg::rf_addr_w'($random(seed));
            write_entry(addr, rand_data());
            read_entry(addr);
            read_entry(rf_pkg::rf_addr_w'($random(seed)));
        end

        // Isolation hides the held word and gives it back afterwards
        read_entry(addr);
        @(posedge wclk) pwr.isol_en <= 1'b1;
        idle(3);
        @(posedge wclk) pwr.isol_en <= 1'b0;
        idle(3);

        // A memory reset pulse forgets every word
        idle(5);
        @(posedge wclk) ip_reset_b <= 1'b0;
        idle(5);
        @(posedge wclk) ip_reset_b <= 1'b1;
        idle(6);
        read_all();

        // Power cycle with a write attempted while the array is off
        idle(5);
        @(posedge wclk) pwr.pwr_enable_b <= 1'b1;
        idle(5);
        write_entry(4'h9, rand_data());
        read_entry(4'h9);
        idle(5);
        @(posedge wclk) pwr.pwr_enable_b <= 1'b0;
        idle(8);
        read_all();

        // Scan bypass holds the array in memory reset until released
        write_entry(4'h5, rand_data());
        idle(5);
        @(posedge wclk) begin
            fscan_rstbypen <= 1'b1;
            fscan_byprst_b <= 1'b0;
        end
        idle(5);
        write_entry(4'h5, rand_data());
        read_entry(4'h5);
        idle(5);
        @(posedge wclk) begin
            fscan_rstbypen <= 1'b0;
            fscan_byprst_b <= 1'b1;
        end
        idle(5);
        // The write made during the bypass must have left entry 5 empty
        read_entry(4'h5);
        write_entry(4'h5, rand_data());
        read_entry(4'h5);
        idle(4);

        $display("Checks %0d, data errors %0d, power errors %0d, assertion errors %0d",
                 checks, data_errors, pwr_errors, u_rf_pg_16x180.u_props.assert_errors);
        if (data_errors + pwr_errors + u_rf_pg_16x180.u_props.assert_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog in case a wait never returns
    initial begin
        #(test_cycles * 20 + 4000);
        $display("Timeout: the tests did not finish within %0d cycles", test_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
common/rf_pkg.sv
logic/mem_reset_sync.sv
rf_array/rf_pwr_seq.sv
rf_array/rf_array_2p.sv
rf_array/rf_pg_16x180.sv
tb/rf_pg_props.sv
tb/rf_pg_checker.sv
tb/tb_rf_pg.sv
